/* common/replay_consts.svh */
`ifndef REPLAY_CONSTS_SVH
`define REPLAY_CONSTS_SVH

// bits per word read from the input FIFO
`define REPLAY_AXI_WIDTH 64

// every logging unit starts and ends on this grid
`define REPLAY_ALIGN 8
`define REPLAY_ALIGN_BITS 3

// largest logging unit, header included
`define REPLAY_UNIT_WIDTH 192

// length field at the bottom of each unit, in bits
`define REPLAY_OFFSET_WIDTH 8

// unit length counted in alignment units, up to 24
`define REPLAY_ALIGNED_LEN_WIDTH (`REPLAY_OFFSET_WIDTH - `REPLAY_ALIGN_BITS)

// alignment units held in one input word
`define REPLAY_AXI_ALIGNED (`REPLAY_AXI_WIDTH / `REPLAY_ALIGN)
// offset of an alignment unit inside one word
`define REPLAY_AXI_OFF_WIDTH 3

// word slots needed to hold the largest unit
`define REPLAY_NUM_AXI ((`REPLAY_UNIT_WIDTH + `REPLAY_AXI_WIDTH - 1) / `REPLAY_AXI_WIDTH)

// replay bit totals and running counts
`define REPLAY_CNT_WIDTH 64

`endif

/* common/replay_pkg.sv */
`include "replay_consts.svh"

package replay_pkg;

    // HI half of the shifting buffer
    typedef enum logic [0:0] {
        HI_EMPTY,
        HI_FULL
    } hi_state_t;

    // LO half, header word or continuation of a long unit
    typedef enum logic [1:0] {
        LO_EMPTY,
        LO_HEADER,
        LO_BODY
    } lo_state_t;

    // assembler, done state is the output strobe
    typedef enum logic [1:0] {
        ASM_WAIT_HEADER,
        ASM_WAIT_BODY,
        ASM_DONE
    } asm_state_t;

    typedef logic [`REPLAY_AXI_WIDTH-1:0] axi_word_t;
    typedef logic [`REPLAY_UNIT_WIDTH-1:0] unit_t;
    typedef logic [`REPLAY_ALIGNED_LEN_WIDTH-1:0] aligned_len_t;

endpackage

/* logic/replay_assembler.sv */
`timescale 1ns/100ps
`include "replay_consts.svh"

module replay_assembler import replay_pkg::*; (
    input  logic                            clk,
    input  logic                            sync_rst_n,
    input  logic                            asm_valid,
    input  axi_word_t                       asm_data,
    input  logic [`REPLAY_OFFSET_WIDTH-1:0] asm_len,
    output unit_t                           out_data,
    output logic                            out_wr_en
);

    localparam int SLOT_WIDTH = $clog2(`REPLAY_NUM_AXI);
    localparam int COVER_WIDTH = `REPLAY_OFFSET_WIDTH + 1;

    asm_state_t asm_state, asm_state_next;

    axi_word_t                       unit_slots [`REPLAY_NUM_AXI];
    logic [SLOT_WIDTH-1:0]           slot_cnt;
    logic [SLOT_WIDTH:0]             slot_cnt_next;
    logic [`REPLAY_OFFSET_WIDTH-1:0] unit_len;
    logic                            header_fits;
    logic                            body_covers;

    // header word alone holds the whole unit
    assign header_fits = asm_len <= `REPLAY_OFFSET_WIDTH'(`REPLAY_AXI_WIDTH);

    // words received so far, this one included, cover the length
    assign slot_cnt_next = {1'b0, slot_cnt} + 1'b1;
    assign body_covers = COVER_WIDTH'(unit_len) <=
                         COVER_WIDTH'(slot_cnt_next) * COVER_WIDTH'(`REPLAY_AXI_WIDTH);

    always_comb begin
        asm_state_next = asm_state;
        case (asm_state)
            ASM_WAIT_HEADER, ASM_DONE: begin
                // from DONE a new header loads without a bubble
                if (asm_valid) begin
                    asm_state_next = header_fits ? ASM_DONE : ASM_WAIT_BODY;
                end else begin
                    asm_state_next = ASM_WAIT_HEADER;
                end
            end
            ASM_WAIT_BODY: begin
                if (asm_valid && body_covers) begin
                    asm_state_next = ASM_DONE;
                end
            end
            default: begin
                asm_state_next = ASM_WAIT_HEADER;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            asm_state <= ASM_WAIT_HEADER;
            slot_cnt <= '0;
            unit_len <= '0;
        end else begin
            asm_state <= asm_state_next;
            if (asm_state == ASM_WAIT_BODY) begin
                if (asm_valid) begin
                    slot_cnt <= slot_cnt_next[SLOT_WIDTH-1:0];
                end
            end else if (asm_valid) begin
                // header word goes to slot 0
                unit_len <= asm_len;
                slot_cnt <= SLOT_WIDTH'(1);
            end
        end
    end

    // unit buffer, slots above the length keep stale data
    always_ff @(posedge clk) begin
        if (asm_valid) begin
            if (asm_state == ASM_WAIT_BODY) begin
                unit_slots[slot_cnt] <= asm_data;
            end else begin
                unit_slots[0] <= asm_data;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `REPLAY_NUM_AXI; i++) begin
            out_data[i*`REPLAY_AXI_WIDTH +: `REPLAY_AXI_WIDTH] = unit_slots[i];
        end
    end

    // one write per unit, the cycle spent in DONE
    assign out_wr_en = (asm_state == ASM_DONE);

endmodule

/* logic/replay_trace_parser.sv */
`timescale 1ns/100ps
`include "replay_consts.svh"

module replay_trace_parser import replay_pkg::*; (
    input  logic                           clk,
    input  logic                           sync_rst_n,
    input  axi_word_t                      in_data,
    input  logic                           in_empty,
    input  logic                           out_almfull,
    input  logic [`REPLAY_CNT_WIDTH-1:0]   replay_bits,
    output logic                           in_rd_en,
    output unit_t                          out_data,
    output logic                           out_wr_en,
    output logic [`REPLAY_CNT_WIDTH-1:0]   rt_replay_bits
);

    // HI and LO halves of the shifting buffer
    logic      hi_full;
    axi_word_t hi_data;
    logic      hi_lo_shift;

    // registered hand-over into the assembler
    logic                            asm_valid;
    axi_word_t                       asm_data;
    logic [`REPLAY_OFFSET_WIDTH-1:0] asm_len;

    replay_hi_stage u_hi_stage (
        .clk         (clk),
        .sync_rst_n  (sync_rst_n),
        .in_data     (in_data),
        .in_empty    (in_empty),
        .out_almfull (out_almfull),
        .replay_bits (replay_bits),
        .hi_lo_shift (hi_lo_shift),
        .in_rd_en    (in_rd_en),
        .hi_full     (hi_full),
        .hi_data     (hi_data)
    );

    replay_lo_stage u_lo_stage (
        .clk            (clk),
        .sync_rst_n     (sync_rst_n),
        .hi_full        (hi_full),
        .hi_data        (hi_data),
        .replay_bits    (replay_bits),
        .hi_lo_shift    (hi_lo_shift),
        .asm_valid      (asm_valid),
        .asm_data       (asm_data),
        .asm_len        (asm_len),
        .rt_replay_bits (rt_replay_bits)
    );

    replay_assembler u_assembler (
        .clk        (clk),
        .sync_rst_n (sync_rst_n),
        .asm_valid  (asm_valid),
        .asm_data   (asm_data),
        .asm_len    (asm_len),
        .out_data   (out_data),
        .out_wr_en  (out_wr_en)
    );

endmodule

/* replay_trace_parser.f */
+incdir+common
common/replay_pkg.sv
shift_buffer/replay_hi_stage.sv
shift_buffer/replay_lo_stage.sv
logic/replay_assembler.sv
logic/replay_trace_parser.sv
verification/replay_trace_checker.sv
verification/replay_trace_parser_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the replay trace parser testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
    --top-module replay_trace_parser_tb \
    -f replay_trace_parser.f

./obj_dir/Vreplay_trace_parser_tb > sim.log
cat sim.log

if grep -q "SIMULATION PASSED" sim.log; then
    echo "run ok"
    exit 0
else
    echo "run failed, see sim.log"
    exit 1
fi

/* shift_buffer/replay_hi_stage.sv */
`timescale 1ns/100ps
`include "replay_consts.svh"

module replay_hi_stage import replay_pkg::*; (
    input  logic                          clk,
    input  logic                          sync_rst_n,
    input  axi_word_t                     in_data,
    input  logic                          in_empty,
    input  logic                          out_almfull,
    input  logic [`REPLAY_CNT_WIDTH-1:0]  replay_bits,
    input  logic                          hi_lo_shift,
    output logic                          in_rd_en,
    output logic                          hi_full,
    output axi_word_t                     hi_data
);

    // bit offset width inside one input word
    localparam int WORD_BITS = `REPLAY_AXI_OFF_WIDTH + `REPLAY_ALIGN_BITS;
    localparam int WCNT_WIDTH = `REPLAY_CNT_WIDTH - WORD_BITS;

    hi_state_t hi_state, hi_state_next;

    logic                          hi_pad_last;
    logic                          hi_load;
    logic [`REPLAY_CNT_WIDTH-1:0]  bits_round_up;
    logic [WCNT_WIDTH-1:0]         word_total;
    logic [WCNT_WIDTH-1:0]         word_cnt;

    assign hi_full = (hi_state == HI_FULL);

    // read only with room in HI and no output back-pressure
    assign in_rd_en = !in_empty && !out_almfull && (!hi_full || hi_lo_shift);

    // words needed to carry the whole trace
    assign bits_round_up = replay_bits + (`REPLAY_AXI_WIDTH - 1);
    assign word_total = bits_round_up[`REPLAY_CNT_WIDTH-1:WORD_BITS];

    // once every trace word is in, push one zero word behind it
    // so the last unit in LO has a full HI next to it
    assign hi_pad_last = (word_cnt != '0) && (word_cnt == word_total) &&
                         (!hi_full || hi_lo_shift);

    assign hi_load = in_rd_en || hi_pad_last;

    always_comb begin
        case (hi_state)
            HI_EMPTY: begin
                hi_state_next = hi_load ? HI_FULL : HI_EMPTY;
            end
            HI_FULL: begin
                // shift with a new load keeps HI full
                if (hi_lo_shift && !hi_load) begin
                    hi_state_next = HI_EMPTY;
                end else begin
                    hi_state_next = HI_FULL;
                end
            end
            default: begin
                hi_state_next = HI_EMPTY;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            hi_state <= HI_EMPTY;
            word_cnt <= '0;
        end else begin
            hi_state <= hi_state_next;
            // the padding word counts too, so it is only inserted once
            if (hi_load) begin
                word_cnt <= word_cnt + 1'b1;
            end
        end
    end

    // HI word, FIFO data wins over padding
    always_ff @(posedge clk) begin
        if (in_rd_en) begin
            hi_data <= in_data;
        end else if (hi_pad_last) begin
            hi_data <= '0;
        end
    end

endmodule

/* shift_buffer/replay_lo_stage.sv */
`timescale 1ns/100ps
`include "replay_consts.svh"

module replay_lo_stage import replay_pkg::*; (
    input  logic                            clk,
    input  logic                            sync_rst_n,
    input  logic                            hi_full,
    input  axi_word_t                       hi_data,
    input  logic [`REPLAY_CNT_WIDTH-1:0]    replay_bits,
    output logic                            hi_lo_shift,
    output logic                            asm_valid,
    output axi_word_t                       asm_data,
    output logic [`REPLAY_OFFSET_WIDTH-1:0] asm_len,
    output logic [`REPLAY_CNT_WIDTH-1:0]    rt_replay_bits
);

    localparam int SUM_WIDTH = `REPLAY_ALIGNED_LEN_WIDTH + 1;
    localparam int PKT_WIDTH = `REPLAY_CNT_WIDTH - `REPLAY_ALIGN_BITS;

    lo_state_t lo_state, lo_state_next;

    axi_word_t                                           lo_word;
    logic [2*`REPLAY_AXI_ALIGNED-1:0][`REPLAY_ALIGN-1:0] window;
    logic [`REPLAY_AXI_OFF_WIDTH-1:0]                    lo_valid_off;
    logic [`REPLAY_AXI_OFF_WIDTH:0]                      off_ext;
    axi_word_t                                           lo_out_data;
    logic                                                lo_empty;
    logic                                                lo_out;
    aligned_len_t                                        lo_remain_len;
    aligned_len_t                                        lo_remain_len_reg;
    logic [SUM_WIDTH-1:0]                                exhaust_sum;
    logic                                                lo_exhaust;
    logic                                                lo_valid_satisfied;
    logic [`REPLAY_AXI_OFF_WIDTH-1:0]                    off_advance;
    logic [PKT_WIDTH-1:0]                                pkt_total;
    logic [PKT_WIDTH-1:0]                                pkt_cnt;
    aligned_len_t                                        pkt_cnt_add;
    logic                                                lo_replay_done;

    // two-word window with LO below HI, read at the valid offset
    assign window = {hi_data, lo_word};
    assign off_ext = {1'b0, lo_valid_off};
    assign lo_out_data = window[off_ext +: `REPLAY_AXI_ALIGNED];

    assign lo_empty = (lo_state == LO_EMPTY);
    // output needs HI full so the window is contiguous
    assign lo_out = hi_full && !lo_empty;
    assign hi_lo_shift = hi_full && (lo_empty || (lo_out && lo_exhaust));

    // remaining length comes from the header or from the body register
    always_comb begin
        case (lo_state)
            LO_HEADER: lo_remain_len = lo_out_data[`REPLAY_ALIGN_BITS +: `REPLAY_ALIGNED_LEN_WIDTH];
            LO_BODY:   lo_remain_len = lo_remain_len_reg;
            default:   lo_remain_len = '0;
        endcase
    end

    // widened so a long unit at a high offset cannot wrap
    assign exhaust_sum = SUM_WIDTH'(lo_remain_len) + SUM_WIDTH'(lo_valid_off);
    assign lo_exhaust = exhaust_sum >= SUM_WIDTH'(`REPLAY_AXI_ALIGNED);
    // rest of the unit fits in this output
    assign lo_valid_satisfied = lo_remain_len <= aligned_len_t'(`REPLAY_AXI_ALIGNED);
    assign off_advance = lo_valid_off + lo_remain_len[`REPLAY_AXI_OFF_WIDTH-1:0];

    always_comb begin
        lo_state_next = lo_state;
        case (lo_state)
            LO_EMPTY: begin
                if (hi_lo_shift) begin
                    lo_state_next = LO_HEADER;
                end
            end
            LO_HEADER: begin
                // long unit carries on into the next word
                if (hi_lo_shift && !lo_valid_satisfied) begin
                    lo_state_next = LO_BODY;
                end
            end
            LO_BODY: begin
                // unit tail sent so the next window starts with a header
                if (lo_out && lo_valid_satisfied) begin
                    lo_state_next = LO_HEADER;
                end
            end
            default: begin
                lo_state_next = LO_EMPTY;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            lo_state <= LO_EMPTY;
            lo_valid_off <= '0;
        end else begin
            lo_state <= lo_state_next;
            if (lo_out && lo_valid_satisfied) begin
                // wraps to the new LO word when the unit ends exactly on it
                lo_valid_off <= off_advance;
            end
        end
    end

    // LO word and body length qualified by the state machine
    always_ff @(posedge clk) begin
        if (hi_lo_shift) begin
            lo_word <= hi_data;
        end
        if (hi_lo_shift && !lo_valid_satisfied) begin
            lo_remain_len_reg <= lo_remain_len - aligned_len_t'(`REPLAY_AXI_ALIGNED);
        end
    end

    // alignment units handed to the assembler with one cycle per stage
    assign pkt_total = replay_bits[`REPLAY_CNT_WIDTH-1:`REPLAY_ALIGN_BITS];
    assign lo_replay_done = (pkt_total == pkt_cnt + PKT_WIDTH'(pkt_cnt_add));
    assign rt_replay_bits = {pkt_cnt, {`REPLAY_ALIGN_BITS{1'b0}}};

    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            pkt_cnt <= '0;
            pkt_cnt_add <= '0;
        end else begin
            pkt_cnt <= pkt_cnt + PKT_WIDTH'(pkt_cnt_add);
            if (lo_out && !lo_replay_done) begin
                pkt_cnt_add <= lo_valid_satisfied ? lo_remain_len :
                               aligned_len_t'(`REPLAY_AXI_ALIGNED);
            end else begin
                pkt_cnt_add <= '0;
            end
        end
    end

    // register barrier towards the assembler
    // trailing padding never raises the strobe
    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            asm_valid <= 1'b0;
        end else begin
            asm_valid <= lo_out && !lo_replay_done;
        end
    end

    always_ff @(posedge clk) begin
        asm_data <= lo_out_data;
        asm_len <= {lo_remain_len, {`REPLAY_ALIGN_BITS{1'b0}}};
    end

endmodule

/* verification/replay_trace_checker.sv */
`timescale 1ns/100ps
`include "replay_consts.svh"

module replay_trace_checker import replay_pkg::*; (
    input logic                         clk,
    input logic                         sync_rst_n,
    input logic                         in_rd_en,
    input logic                         out_almfull,
    input logic                         out_wr_en,
    input unit_t                        out_data,
    input logic [`REPLAY_CNT_WIDTH-1:0] rt_replay_bits
);

    // expected units in output order, lengths in bits
    unit_t exp_units [$];
    int    exp_lens [$];

    string test_name;
    int    units_left = 0;
    int    unit_idx = 0;
    int    test_errors = 0;
    int    total_errors = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    unit_t exp_unit;
    unit_t exp_mask;
    int    exp_len;

    // bits above the unit length are stale in out_data
    function automatic unit_t len_mask(input int len_bits);
        unit_t m;
        m = '0;
        for (int i = 0; i < len_bits; i++) begin
            m[i] = 1'b1;
        end
        return m;
    endfunction

    task automatic start_test(input string name);
        test_name = name;
        test_errors = 0;
        unit_idx = 0;
    endtask

    task automatic expect_unit(input unit_t unit, input int len_bits);
        exp_units.push_back(unit);
        exp_lens.push_back(len_bits);
        units_left++;
    endtask

    // outputs are registered, so the falling edge sees settled values
    always @(negedge clk) begin
        if (sync_rst_n) begin
            if (in_rd_en && out_almfull) begin
                $display("ERROR at %0t: input word read while output FIFO almost full", $time);
                test_errors++;
            end
            if (out_wr_en && units_left == 0) begin
                $display("ERROR at %0t: extra unit written in test %s", $time, test_name);
                test_errors++;
            end else if (out_wr_en) begin
                exp_unit = exp_units.pop_front();
                exp_len = exp_lens.pop_front();
                units_left--;
                exp_mask = len_mask(exp_len);
                if ((out_data & exp_mask) != exp_unit) begin
                    $display("CHECK FAILED at %0t: %s unit %0d (%0d bits) got %h expected %h",
                             $time, test_name, unit_idx, exp_len, out_data & exp_mask, exp_unit);
                    test_errors++;
                end
                unit_idx++;
            end
        end
    end

    // rt_replay_bits lags LO, so this runs a few cycles after the last write
    task automatic finish_test(input logic [`REPLAY_CNT_WIDTH-1:0] exp_bits);
        if (units_left != 0) begin
            $display("ERROR at %0t: %0d units of test %s never written",
                     $time, units_left, test_name);
            test_errors++;
            exp_units.delete();
            exp_lens.delete();
            units_left = 0;
        end
        if (rt_replay_bits != exp_bits) begin
            $display("CHECK FAILED at %0t: %s replayed %0d bits, expected %0d",
                     $time, test_name, rt_replay_bits, exp_bits);
            test_errors++;
        end
        tests_run++;
        total_errors += test_errors;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("test %-14s units %4d  errors %0d  %s", test_name, unit_idx, test_errors,
                 (test_errors == 0) ? "ok" : "failed");
    endtask

    task automatic report_counts();
        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
                 total_errors);
    endtask

endmodule

/* verification/replay_trace_parser_tb.sv */
`timescale 1ns/100ps
`include "replay_consts.svh"

module replay_trace_parser_tb import replay_pkg::*; ();

    logic                         clk;
    logic                         sync_rst_n;
    axi_word_t                    in_data;
    logic                         in_empty;
    logic                         out_almfull;
    logic [`REPLAY_CNT_WIDTH-1:0] replay_bits;
    logic                         in_rd_en;
    unit_t                        out_data;
    logic                         out_wr_en;
    logic [`REPLAY_CNT_WIDTH-1:0] rt_replay_bits;

    // input FIFO contents and the byte stream packed into them
    axi_word_t   in_words [$];
    logic [7:0]  trace_bytes [$];
    int          trace_bits;
    int          cycle_cnt = 0;
    int          cycle_limit = 0;
    int unsigned seed_ret;

    replay_trace_parser DUT (
        .clk            (clk),
        .sync_rst_n     (sync_rst_n),
        .in_data        (in_data),
        .in_empty       (in_empty),
        .out_almfull    (out_almfull),
        .replay_bits    (replay_bits),
        .in_rd_en       (in_rd_en),
        .out_data       (out_data),
        .out_wr_en      (out_wr_en),
        .rt_replay_bits (rt_replay_bits)
    );

    replay_trace_checker u_checker (
        .clk            (clk),
        .sync_rst_n     (sync_rst_n),
        .in_rd_en       (in_rd_en),
        .out_almfull    (out_almfull),
        .out_wr_en      (out_wr_en),
        .out_data       (out_data),
        .rt_replay_bits (rt_replay_bits)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // header byte holds the length in bits, the rest is random payload
    task automatic add_unit(input int len_au);
        unit_t      unit;
        logic [7:0] b;
        unit = '0;
        for (int j = 0; j < len_au; j++) begin
            b = (j == 0) ? 8'(len_au * `REPLAY_ALIGN) : 8'($urandom);
            trace_bytes.push_back(b);
            unit[j*`REPLAY_ALIGN +: `REPLAY_ALIGN] = b;
        end
        u_checker.expect_unit(unit, len_au * `REPLAY_ALIGN);
        trace_bits += len_au * `REPLAY_ALIGN;
    endtask

    // units packed LSB first, tail of the last word zero
    task automatic build_trace(input int n_units, input int min_au, input int max_au,
                               input bit end_on_word);
        axi_word_t w;
        int        n_words;
        trace_bytes.delete();
        in_words.delete();
        trace_bits = 0;
        for (int i = 0; i < n_units; i++) begin
            add_unit(min_au + int'($urandom % (max_au - min_au + 1)));
        end
        // filler unit so the trace closes exactly on a word boundary
        if (end_on_word && (trace_bytes.size() % 8) != 0) begin
            add_unit(8 - (trace_bytes.size() % 8));
        end
        n_words = (trace_bytes.size() + 7) / 8;
        for (int i = 0; i < n_words; i++) begin
            w = '0;
            for (int k = 0; k < 8; k++) begin
                if (i * 8 + k < trace_bytes.size()) begin
                    w[k*8 +: 8] = trace_bytes[i*8+k];
                end
            end
            in_words.push_back(w);
        end
        cycle_limit += 4 * n_words + 200;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        sync_rst_n = 1'b0;
        in_empty = 1'b1;
        in_data = '0;
        out_almfull = 1'b0;
        replay_bits = 64'(trace_bits);
        repeat (4) begin
            @(posedge clk);
        end
        #1;
        sync_rst_n = 1'b1;
    endtask

    // FIFO models, read strobe taken at the falling edge before it is used
    task automatic drive_cycle(input int gap_pct, input int almfull_pct);
        logic rd_seen;
        @(negedge clk);
        rd_seen = in_rd_en;
        @(posedge clk);
        #1;
        if (rd_seen && in_words.size() != 0) begin
            in_words.delete(0);
        end
        in_empty = (in_words.size() == 0) || (($urandom % 100) < gap_pct);
        in_data = (in_words.size() != 0) ? in_words[0] : '0;
        if (almfull_pct == 0) begin
            out_almfull = 1'b0;
        end else if (out_almfull) begin
            // pulses last a few cycles
            out_almfull = ($urandom % 100) < 60;
        end else begin
            out_almfull = ($urandom % 100) < almfull_pct;
        end
    endtask

    task automatic run_test(input string name, input int n_units, input int min_au,
                            input int max_au, input int gap_pct, input int almfull_pct,
                            input bit end_on_word);
        u_checker.start_test(name);
        build_trace(n_units, min_au, max_au, end_on_word);
        apply_reset();
        while (u_checker.units_left != 0) begin
            drive_cycle(gap_pct, almfull_pct);
        end
        // idle tail, padding must not raise another write
        repeat (30) begin
            drive_cycle(0, 0);
        end
        u_checker.finish_test(replay_bits);
    endtask

    initial begin
        seed_ret = $urandom(32'hdac3);
        sync_rst_n = 1'b0;
        in_empty = 1'b1;
        in_data = '0;
        out_almfull = 1'b0;
        replay_bits = '0;
        run_test("short_units", 40, 1, 8, 0, 0, 1'b0);
        run_test("long_units", 20, 9, 24, 0, 0, 1'b0);
        run_test("empty_gaps", 40, 1, 24, 30, 0, 1'b0);
        run_test("almfull", 40, 1, 24, 15, 20, 1'b0);
        run_test("word_end", 30, 1, 24, 10, 0, 1'b1);
        u_checker.report_counts();
        if (u_checker.total_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // limit grows as each test is built, before its first cycle
    initial begin
        @(posedge clk);
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("ERROR: timeout after %0d cycles, the DUT stopped writing units", cycle_cnt);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule
